//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_jpeg_out \
    -Mdir "$BUILD_DIR" -o tb_jpeg_out
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_jpeg_out" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim.f
src/jpeg_stream_pkg.sv
src/wb_pkg.sv
src/byte_stuffer.sv
src/byte_packer.sv
src/wb_stream_writer.sv
src/wb_arbiter.sv
src/wb_ram.sv
src/jpeg_out_top.sv
test/tb_jpeg_out.sv

//--- src/byte_packer.sv
`default_nettype none
`timescale 1ns/100ps

module byte_packer (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  logic [8*jpeg_stream_pkg::OUT_BYTES-1:0]   in_data,
    input  logic [jpeg_stream_pkg::OUT_NB_W-1:0]      in_nbytes,
    input  logic                                      in_tlast,
    input  logic                                      in_valid,
    output logic                                      in_hold,
    output logic [31:0]                               word,
    output logic [jpeg_stream_pkg::IN_NB_W-1:0]       word_nbytes,
    output logic                                      word_last,
    output logic                                      word_valid,
    input  logic                                      word_hold
);
    import jpeg_stream_pkg::*;

    localparam int BUF_BYTES = 2 * OUT_BYTES;
    localparam int CNT_W = $clog2(BUF_BYTES + 1);

    // oldest byte sits at the top, everything past count is kept at zero
    logic [8*BUF_BYTES-1:0]   pack_q;
    logic [8*BUF_BYTES-1:0]   pack_popped;
    logic [8*BUF_BYTES-1:0]   pack_next;
    logic [CNT_W-1:0]         count;
    logic [CNT_W-1:0]         count_popped;
    logic [CNT_W-1:0]         count_next;
    logic [8*OUT_BYTES-1:0]   in_masked;
    logic                     last_pending;
    logic                     push;
    logic                     pop;

    assign word = pack_q[8*BUF_BYTES-1 -: 32];
    assign word_nbytes = (count >= IN_BYTES) ? IN_NB_W'(IN_BYTES) : count[IN_NB_W-1:0];
    assign word_valid = (count >= IN_BYTES) || last_pending;
    assign word_last = last_pending && (count <= IN_BYTES);

    // a new frame waits until the previous one has been flushed
    assign in_hold = last_pending || (count > OUT_BYTES);

    assign pop = word_valid && !word_hold;
    assign push = in_valid && !in_hold;

    // drop the bytes the stuffer left past its count
    assign in_masked = in_data & ~({8*OUT_BYTES{1'b1}} >> (8*in_nbytes));

    always_comb begin
        pack_popped = pop ? (pack_q << 32) : pack_q;
        count_popped = pop ? (count - CNT_W'(word_nbytes)) : count;
        pack_next = pack_popped;
        count_next = count_popped;
        if (push) begin
            pack_next = pack_popped
                      | ({in_masked, {8*OUT_BYTES{1'b0}}} >> (8*count_popped));
            count_next = count_popped + CNT_W'(in_nbytes);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            pack_q <= '0;
            count <= '0;
            last_pending <= 1'b0;
        end else begin
            pack_q <= pack_next;
            count <= count_next;
            if (push && in_tlast) begin
                last_pending <= 1'b1;
            end else if (pop && word_last) begin
                last_pending <= 1'b0;
            end
        end
    end

    a_count_limit: assert property (@(posedge clk) disable iff (resetn)
        count <= BUF_BYTES);

endmodule

`default_nettype wire

//--- src/byte_stuffer.sv
`default_nettype none
`timescale 1ns/100ps

module byte_stuffer (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  logic [8*jpeg_stream_pkg::IN_BYTES-1:0]    in_data,
    input  logic [jpeg_stream_pkg::IN_NB_W-1:0]       in_nbytes,
    input  logic                                      in_tlast,
    input  logic                                      in_valid,
    output logic                                      in_hold,
    output logic [8*jpeg_stream_pkg::OUT_BYTES-1:0]   out_data,
    output logic [jpeg_stream_pkg::OUT_NB_W-1:0]      out_nbytes,
    output logic                                      out_tlast,
    output logic                                      out_valid,
    input  logic                                      out_hold
);
    import jpeg_stream_pkg::*;

    logic [IN_BYTES-1:0]      is_ff;
    logic [8*OUT_BYTES-1:0]   stuffed;
    logic [8*OUT_BYTES-1:0]   keep;
    logic [OUT_NB_W-1:0]      ff_count;

    // index 0 is the last byte of the chunk, bytes past in_nbytes are ignored
    always_comb begin
        for (int i = 0; i < IN_BYTES; i++) begin
            is_ff[i] = (in_data[8*i +: 8] == 8'hff) && (IN_BYTES - 1 - i < in_nbytes);
        end
    end

    // work from the low bytes up so that an insertion never moves a byte
    // that is still to be examined
    always_comb begin
        stuffed = {in_data, {8*(OUT_BYTES-IN_BYTES){1'b0}}};
        ff_count = '0;
        for (int i = 0; i < IN_BYTES; i++) begin
            keep = {8*OUT_BYTES{1'b1}} << (8*(OUT_BYTES - IN_BYTES + i));
            if (is_ff[i]) begin
                stuffed = (stuffed & keep) | ((stuffed & ~keep) >> 8);
                ff_count = ff_count + 1'b1;
            end
        end
    end

    // only stall when the register is full and downstream refuses it
    assign in_hold = out_hold && out_valid;

    always_ff @(posedge clk) begin
        if (resetn) begin
            out_valid <= 1'b0;
        end else if (!in_hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!in_hold && in_valid) begin
            out_data <= stuffed;
            out_nbytes <= OUT_NB_W'(in_nbytes) + ff_count;
            out_tlast <= in_tlast;
        end
    end

    a_in_nbytes_range: assert property (@(posedge clk) disable iff (resetn)
        in_valid |-> in_nbytes <= IN_BYTES);

endmodule

`default_nettype wire

//--- src/jpeg_out_top.sv
`default_nettype none
`timescale 1ns/100ps

module jpeg_out_top #(
    parameter logic [wb_pkg::WB_AW-1:0] CH0_BASE = 12'd0,
    parameter logic [wb_pkg::WB_AW-1:0] CH1_BASE = 12'd2048,
    parameter int MEM_WORDS = 4096
) (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  logic [8*jpeg_stream_pkg::IN_BYTES-1:0]    s0_data,
    input  logic [jpeg_stream_pkg::IN_NB_W-1:0]       s0_nbytes,
    input  logic                                      s0_tlast,
    input  logic                                      s0_valid,
    output logic                                      s0_hold,
    output logic                                      s0_done,
    output logic [jpeg_stream_pkg::LEN_W-1:0]         s0_bytes,
    input  logic [8*jpeg_stream_pkg::IN_BYTES-1:0]    s1_data,
    input  logic [jpeg_stream_pkg::IN_NB_W-1:0]       s1_nbytes,
    input  logic                                      s1_tlast,
    input  logic                                      s1_valid,
    output logic                                      s1_hold,
    output logic                                      s1_done,
    output logic [jpeg_stream_pkg::LEN_W-1:0]         s1_bytes,
    input  logic [wb_pkg::WB_AW-1:0]                  rd_addr,
    output logic [wb_pkg::WB_DW-1:0]                  rd_data
);
    import jpeg_stream_pkg::*;
    import wb_pkg::*;

    // stuffed chunks
    logic [8*OUT_BYTES-1:0]   st0_data, st1_data;
    logic [OUT_NB_W-1:0]      st0_nbytes, st1_nbytes;
    logic                     st0_tlast, st1_tlast, st0_valid, st1_valid, st0_hold, st1_hold;

    // packed words
    logic [WB_DW-1:0]         pk0_word, pk1_word;
    logic [IN_NB_W-1:0]       pk0_nbytes, pk1_nbytes;
    logic                     pk0_last, pk1_last, pk0_valid, pk1_valid, pk0_hold, pk1_hold;

    // master side and shared slave side of the bus
    logic                     m0_cyc, m0_stb, m0_we, m0_ack, m1_cyc, m1_stb, m1_we, m1_ack;
    logic [WB_AW-1:0]         m0_adr, m1_adr, s_adr;
    logic [WB_DW-1:0]         m0_dat_w, m1_dat_w, s_dat_w;
    logic                     s_cyc, s_stb, s_we, s_ack;

    byte_stuffer u_stuff0 (
        .clk, .resetn,
        .in_data(s0_data), .in_nbytes(s0_nbytes), .in_tlast(s0_tlast),
        .in_valid(s0_valid), .in_hold(s0_hold),
        .out_data(st0_data), .out_nbytes(st0_nbytes), .out_tlast(st0_tlast),
        .out_valid(st0_valid), .out_hold(st0_hold)
    );

    byte_stuffer u_stuff1 (
        .clk, .resetn,
        .in_data(s1_data), .in_nbytes(s1_nbytes), .in_tlast(s1_tlast),
        .in_valid(s1_valid), .in_hold(s1_hold),
        .out_data(st1_data), .out_nbytes(st1_nbytes), .out_tlast(st1_tlast),
        .out_valid(st1_valid), .out_hold(st1_hold)
    );

    byte_packer u_pack0 (
        .clk, .resetn,
        .in_data(st0_data), .in_nbytes(st0_nbytes), .in_tlast(st0_tlast),
        .in_valid(st0_valid), .in_hold(st0_hold),
        .word(pk0_word), .word_nbytes(pk0_nbytes), .word_last(pk0_last),
        .word_valid(pk0_valid), .word_hold(pk0_hold)
    );

    byte_packer u_pack1 (
        .clk, .resetn,
        .in_data(st1_data), .in_nbytes(st1_nbytes), .in_tlast(st1_tlast),
        .in_valid(st1_valid), .in_hold(st1_hold),
        .word(pk1_word), .word_nbytes(pk1_nbytes), .word_last(pk1_last),
        .word_valid(pk1_valid), .word_hold(pk1_hold)
    );

    wb_stream_writer #(.BASE(CH0_BASE)) u_writer0 (
        .clk, .resetn,
        .word(pk0_word), .word_nbytes(pk0_nbytes), .word_last(pk0_last),
        .word_valid(pk0_valid), .word_hold(pk0_hold),
        .wb_cyc(m0_cyc), .wb_stb(m0_stb), .wb_we(m0_we), .wb_adr(m0_adr),
        .wb_dat_w(m0_dat_w), .wb_ack(m0_ack),
        .frame_done(s0_done), .frame_bytes(s0_bytes)
    );

    wb_stream_writer #(.BASE(CH1_BASE)) u_writer1 (
        .clk, .resetn,
        .word(pk1_word), .word_nbytes(pk1_nbytes), .word_last(pk1_last),
        .word_valid(pk1_valid), .word_hold(pk1_hold),
        .wb_cyc(m1_cyc), .wb_stb(m1_stb), .wb_we(m1_we), .wb_adr(m1_adr),
        .wb_dat_w(m1_dat_w), .wb_ack(m1_ack),
        .frame_done(s1_done), .frame_bytes(s1_bytes)
    );

    wb_arbiter u_arb (
        .clk, .resetn,
        .m0_cyc, .m0_stb, .m0_we, .m0_adr, .m0_dat_w, .m0_ack,
        .m1_cyc, .m1_stb, .m1_we, .m1_adr, .m1_dat_w, .m1_ack,
        .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .s_ack
    );

    wb_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
        .clk, .resetn,
        .wb_cyc(s_cyc), .wb_stb(s_stb), .wb_we(s_we), .wb_adr(s_adr),
        .wb_dat_w(s_dat_w), .wb_ack(s_ack),
        .rd_addr, .rd_data
    );

endmodule

`default_nettype wire

//--- src/jpeg_stream_pkg.sv
`default_nettype none

package jpeg_stream_pkg;

    // bytes in one chunk from the entropy coder
    localparam int IN_BYTES = 4;

    // worst case after stuffing, every input byte was 0xFF
    localparam int OUT_BYTES = 2 * IN_BYTES;

    localparam int IN_NB_W = 3;
    localparam int OUT_NB_W = 4;

    // stuffed byte count of one frame's scan data
    localparam int LEN_W = 16;

endpackage

`default_nettype wire

//--- src/wb_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module wb_arbiter (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          m0_cyc,
    input  logic                          m0_stb,
    input  logic                          m0_we,
    input  logic [wb_pkg::WB_AW-1:0]      m0_adr,
    input  logic [wb_pkg::WB_DW-1:0]      m0_dat_w,
    output logic                          m0_ack,
    input  logic                          m1_cyc,
    input  logic                          m1_stb,
    input  logic                          m1_we,
    input  logic [wb_pkg::WB_AW-1:0]      m1_adr,
    input  logic [wb_pkg::WB_DW-1:0]      m1_dat_w,
    output logic                          m1_ack,
    output logic                          s_cyc,
    output logic                          s_stb,
    output logic                          s_we,
    output logic [wb_pkg::WB_AW-1:0]      s_adr,
    output logic [wb_pkg::WB_DW-1:0]      s_dat_w,
    input  logic                          s_ack
);
    import wb_pkg::*;

    logic [WB_MASTERS-1:0]    req;
    logic                     grant;
    logic                     grant_next;
    logic                     last_served;

    assign req = {m1_cyc, m0_cyc};

    // the grant only moves between cycles of the granted master, and the
    // master not served last wins a tie
    always_comb begin
        grant_next = grant;
        if (!req[grant]) begin
            if (req[!last_served]) begin
                grant_next = !last_served;
            end else if (req[last_served]) begin
                grant_next = last_served;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            grant <= 1'b0;
            last_served <= 1'b1;
        end else begin
            grant <= grant_next;
            if (s_ack) begin
                last_served <= grant;
            end
        end
    end

    assign s_cyc = grant ? m1_cyc : m0_cyc;
    assign s_stb = grant ? m1_stb : m0_stb;
    assign s_we = grant ? m1_we : m0_we;
    assign s_adr = grant ? m1_adr : m0_adr;
    assign s_dat_w = grant ? m1_dat_w : m0_dat_w;
    assign m0_ack = s_ack && !grant;
    assign m1_ack = s_ack && grant;

    // an ack belongs to the master whose request the slave saw a cycle before
    a_ack_to_requester: assert property (@(posedge clk) disable iff (resetn)
        s_ack |-> s_cyc && $past(s_cyc) && (grant == $past(grant)));

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int WB_DW = 32;

    // word address, not byte address
    localparam int WB_AW = 12;

    // one writer per encoder core
    localparam int WB_MASTERS = 2;

endpackage

`default_nettype wire

//--- src/wb_ram.sv
`default_nettype none
`timescale 1ns/100ps

module wb_ram #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [wb_pkg::WB_AW-1:0]      wb_adr,
    input  logic [wb_pkg::WB_DW-1:0]      wb_dat_w,
    output logic                          wb_ack,
    input  logic [wb_pkg::WB_AW-1:0]      rd_addr,
    output logic [wb_pkg::WB_DW-1:0]      rd_data
);
    import wb_pkg::*;

    logic [WB_DW-1:0]   mem [MEM_WORDS];
    logic               req;

    // a request is taken once, ack in the following cycle closes it
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk) begin
        if (resetn) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            mem[wb_adr] <= wb_dat_w;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/wb_stream_writer.sv
`default_nettype none
`timescale 1ns/100ps

module wb_stream_writer #(
    parameter logic [wb_pkg::WB_AW-1:0] BASE = '0
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic [wb_pkg::WB_DW-1:0]              word,
    input  logic [jpeg_stream_pkg::IN_NB_W-1:0]   word_nbytes,
    input  logic                                  word_last,
    input  logic                                  word_valid,
    output logic                                  word_hold,
    output logic                                  wb_cyc,
    output logic                                  wb_stb,
    output logic                                  wb_we,
    output logic [wb_pkg::WB_AW-1:0]              wb_adr,
    output logic [wb_pkg::WB_DW-1:0]              wb_dat_w,
    input  logic                                  wb_ack,
    output logic                                  frame_done,
    output logic [jpeg_stream_pkg::LEN_W-1:0]     frame_bytes
);
    import jpeg_stream_pkg::*;

    logic [IN_NB_W-1:0]   nbytes_q;
    logic                 last_q;
    logic [LEN_W-1:0]     len_acc;
    logic [LEN_W-1:0]     len_next;
    logic                 accept;
    logic                 done_write;

    // one word is in flight and the next is taken once the bus cycle has closed
    assign word_hold = wb_cyc;
    assign wb_we = wb_cyc;
    assign accept = !wb_cyc && word_valid;
    assign done_write = wb_cyc && wb_ack;
    assign len_next = len_acc + LEN_W'(nbytes_q);

    always_ff @(posedge clk) begin
        if (resetn) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_adr <= BASE;
            len_acc <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (accept) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end else if (done_write) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                if (last_q) begin
                    // next frame overwrites the same region
                    wb_adr <= BASE;
                    len_acc <= '0;
                    frame_done <= 1'b1;
                end else begin
                    wb_adr <= wb_adr + 1'b1;
                    len_acc <= len_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_w <= word;
            nbytes_q <= word_nbytes;
            last_q <= word_last;
        end
        if (done_write && last_q) begin
            frame_bytes <= len_next;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (resetn)
        wb_stb |-> wb_cyc);

endmodule

`default_nettype wire

//--- test/tb_jpeg_out.sv
`default_nettype none
`timescale 1ns/100ps

module tb_jpeg_out;
    import jpeg_stream_pkg::*;
    import wb_pkg::*;

    localparam logic [WB_AW-1:0] CH0_BASE = 12'd0;
    localparam logic [WB_AW-1:0] CH1_BASE = 12'd2048;

    // ways of choosing chunk sizes and byte values
    localparam int PLAIN = 0;
    localparam int MIXED = 1;
    localparam int ALL_FF = 2;
    localparam int SPARSE = 3;
    localparam int EMPTY = 4;

    // the number of chunks sent over the whole run sets the watchdog budget
    localparam int TOTAL_CHUNKS = 24 + 60 + 12 + 60 + 26 + 40;

    logic                     clk;
    logic                     resetn;
    logic [8*IN_BYTES-1:0]    s0_data;
    logic [IN_NB_W-1:0]       s0_nbytes;
    logic                     s0_tlast;
    logic                     s0_valid;
    logic                     s0_hold;
    logic                     s0_done;
    logic [LEN_W-1:0]         s0_bytes;
    logic [8*IN_BYTES-1:0]    s1_data;
    logic [IN_NB_W-1:0]       s1_nbytes;
    logic                     s1_tlast;
    logic                     s1_valid;
    logic                     s1_hold;
    logic                     s1_done;
    logic [LEN_W-1:0]         s1_bytes;
    logic [WB_AW-1:0]         rd_addr;
    logic [WB_DW-1:0]         rd_data;

    logic [31:0]   lcg_state = 32'h26a69074;
    logic [7:0]    exp_bytes [2][$];
    int            exp_len [2][$];
    int            got_len [2][$];
    string         cur_name;
    int            test_errs;
    int            tests_run;
    int            tests_failed;

    jpeg_out_top #(
        .CH0_BASE(CH0_BASE),
        .CH1_BASE(CH1_BASE),
        .MEM_WORDS(4096)
    ) dut (
        .clk, .resetn,
        .s0_data, .s0_nbytes, .s0_tlast, .s0_valid, .s0_hold, .s0_done, .s0_bytes,
        .s1_data, .s1_nbytes, .s1_tlast, .s1_valid, .s1_hold, .s1_done, .s1_bytes,
        .rd_addr, .rd_data
    );

    always #2 clk = ~clk;

    // reported frame lengths are sampled away from the active edge
    always @(negedge clk) begin
        if (s0_done) begin
            got_len[0].push_back(int'(s0_bytes));
        end
        if (s1_done) begin
            got_len[1].push_back(int'(s1_bytes));
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    function automatic logic [7:0] plain_byte();
        logic [7:0] b;
        b = 8'(next_rand() >> 12);
        if (b == 8'hff) begin
            b = 8'h5a;
        end
        return b;
    endfunction

    // in the stuffed stream a 0x00 follows every 0xFF
    task automatic push_expected(input int ch, input logic [7:0] b);
        exp_bytes[ch].push_back(b);
        if (b == 8'hff) begin
            exp_bytes[ch].push_back(8'h00);
        end
    endtask

    task automatic drive_inputs(input int ch, input logic [31:0] data, input int nb,
                                input logic last, input logic valid);
        if (ch == 0) begin
            s0_data = data;
            s0_nbytes = IN_NB_W'(nb);
            s0_tlast = last;
            s0_valid = valid;
        end else begin
            s1_data = data;
            s1_nbytes = IN_NB_W'(nb);
            s1_tlast = last;
            s1_valid = valid;
        end
    endtask

    // hold only changes after a rising edge, so its value at the falling
    // edge decides whether the next rising edge takes the chunk
    task automatic send_chunk(input int ch, input logic [31:0] data, input int nb,
                              input logic last);
        logic held;
        @(negedge clk);
        drive_inputs(ch, data, nb, last, 1'b1);
        held = (ch == 0) ? s0_hold : s1_hold;
        while (held) begin
            @(negedge clk);
            held = (ch == 0) ? s0_hold : s1_hold;
        end
        @(posedge clk);
    endtask

    task automatic send_frame(input int ch, input int n_chunks, input int mode);
        logic [31:0] data;
        logic [7:0]  b;
        int          nb;
        int          gap;
        logic        last;
        exp_bytes[ch].delete();
        for (int c = 0; c < n_chunks; c++) begin
            last = (c == n_chunks - 1);
            case (mode)
                PLAIN: nb = 1 + rand_below(4);
                ALL_FF: nb = (c % 2 == 0) ? 4 : rand_below(5);
                SPARSE: nb = (rand_below(3) == 0) ? 0 : 1 + rand_below(4);
                EMPTY: nb = 0;
                default: nb = rand_below(5);
            endcase
            // the tail leaves the stuffed length off a word boundary
            if (mode == SPARSE && last) begin
                nb = (exp_bytes[ch].size() % 4 == 3) ? 2 : 1;
            end
            // unused byte lanes carry random junk that the DUT must ignore
            data = next_rand();
            for (int i = 0; i < nb; i++) begin
                if (mode == ALL_FF && c % 2 == 0) begin
                    b = 8'hff;
                end else if (mode == PLAIN || (mode == SPARSE && last)) begin
                    b = plain_byte();
                end else begin
                    b = (rand_below(4) == 0) ? 8'hff : plain_byte();
                end
                data[31 - 8*i -: 8] = b;
                push_expected(ch, b);
            end
            send_chunk(ch, data, nb, last);
            gap = (mode == SPARSE) ? rand_below(8) : rand_below(3);
            if (gap > 0 || last) begin
                @(negedge clk);
                drive_inputs(ch, '0, 0, 1'b0, 1'b0);
                for (int g = 1; g < gap; g++) begin
                    @(negedge clk);
                end
            end
        end
        exp_len[ch].push_back(exp_bytes[ch].size());
    endtask

    task automatic check_lengths(input int ch);
        int exp_v;
        int got_v;
        while (got_len[ch].size() < exp_len[ch].size()) begin
            @(posedge clk);
        end
        // extra pulses would show up within this window
        repeat (20) @(posedge clk);
        if (got_len[ch].size() != exp_len[ch].size()) begin
            $display("FAILED %s: channel %0d done pulses expected %0d, actual %0d",
                     cur_name, ch, exp_len[ch].size(), got_len[ch].size());
            test_errs++;
        end
        while (got_len[ch].size() > 0 && exp_len[ch].size() > 0) begin
            exp_v = exp_len[ch].pop_front();
            got_v = got_len[ch].pop_front();
            if (got_v != exp_v) begin
                $display("FAILED %s: channel %0d frame length expected %0d, actual %0d",
                         cur_name, ch, exp_v, got_v);
                test_errs++;
            end
        end
        got_len[ch].delete();
        exp_len[ch].delete();
    endtask

    task automatic check_memory(input int ch);
        int          n_words;
        int          idx;
        logic [31:0] exp_w;
        n_words = (exp_bytes[ch].size() + 3) / 4;
        if (n_words == 0) begin
            n_words = 1;
        end
        for (int i = 0; i < n_words; i++) begin
            exp_w = '0;
            for (int k = 0; k < 4; k++) begin
                idx = 4*i + k;
                exp_w = exp_w << 8;
                if (idx < exp_bytes[ch].size()) begin
                    exp_w[7:0] = exp_bytes[ch][idx];
                end
            end
            @(negedge clk);
            rd_addr = WB_AW'(int'((ch == 0) ? CH0_BASE : CH1_BASE) + i);
            @(negedge clk);
            if (rd_data !== exp_w) begin
                $display("FAILED %s: channel %0d word %0d expected %h, actual %h",
                         cur_name, ch, i, exp_w, rd_data);
                test_errs++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s passed", cur_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_name, test_errs);
        end
    endtask

    initial begin
        repeat (16 + 200 * TOTAL_CHUNKS) @(posedge clk);
        $display("timeout: the frames did not complete within the cycle budget");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b1;
        rd_addr = '0;
        tests_run = 0;
        tests_failed = 0;
        drive_inputs(0, '0, 0, 1'b0, 1'b0);
        drive_inputs(1, '0, 0, 1'b0, 1'b0);
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;

        begin_test("plain_ch0");
        send_frame(0, 24, PLAIN);
        check_lengths(0);
        check_memory(0);
        end_test();

        begin_test("random_ff_ch0");
        for (int f = 0; f < 3; f++) begin
            send_frame(0, 20, MIXED);
            check_lengths(0);
            check_memory(0);
        end
        end_test();

        begin_test("all_ff_chunks_ch1");
        send_frame(1, 12, ALL_FF);
        check_lengths(1);
        check_memory(1);
        end_test();

        begin_test("dual_channel");
        fork
            send_frame(0, 30, MIXED);
            send_frame(1, 30, MIXED);
        join
        check_lengths(0);
        check_lengths(1);
        check_memory(0);
        check_memory(1);
        end_test();

        begin_test("sparse_and_empty_ch1");
        send_frame(1, 25, SPARSE);
        check_lengths(1);
        check_memory(1);
        send_frame(1, 1, EMPTY);
        check_lengths(1);
        check_memory(1);
        end_test();

        // only the last frame is still intact in memory afterwards
        begin_test("back_to_back_ch0");
        for (int f = 0; f < 4; f++) begin
            send_frame(0, 10, MIXED);
        end
        check_lengths(0);
        check_memory(0);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
